// File: adc_ctl_assertions.sv
module adc_ctl_assertions (
	input logic ctl_clk,
	input logic arst_n,
	input logic spi_clk,
	input logic spi_cs_n,
	input logic host_busy,
	input logic host_done
);

	// Mode 0 clock parked low outside a frame
	a_clk_idle: assert property (@(posedge ctl_clk) disable iff (!arst_n)
		spi_cs_n |-> !spi_clk)
		else $error("spi_clk toggling with chip select high");

	// Done is a strobe, never a level
	a_done_pulse: assert property (@(posedge ctl_clk) disable iff (!arst_n)
		host_done |=> !host_done)
		else $error("host_done held longer than one cycle");

	// New frame only from an idle writer
	a_cs_open: assert property (@(posedge ctl_clk) disable iff (!arst_n)
		$fell(spi_cs_n) |-> !$past(host_busy))
		else $error("spi_cs_n fell while a frame was open");

endmodule

bind adc_ctl_top adc_ctl_assertions u_assertions (
	.ctl_clk(ctl_clk),
	.arst_n(arst_n),
	.spi_clk(spi_clk),
	.spi_cs_n(spi_cs_n),
	.host_busy(host_busy),
	.host_done(host_done)
);

// File: adc_ctl_pkg.sv
package adc_ctl_pkg;

	//////////////////////////////////////////////////
	// SPI bus

	// ctl_clk cycles per SPI clock half period
	localparam int SPI_CLK_DIV = 5;
	localparam int SPI_DIV_W = 3;	// Holds 0..SPI_CLK_DIV-1

	localparam int SPI_ADDR_W = 8;	// Register address, also one SPI byte
	localparam int SPI_VALUE_W = 16;	// Register value, two bytes
	localparam int SPI_FRAME_BITS = SPI_ADDR_W + SPI_VALUE_W;	// 24 bits per write

	//////////////////////////////////////////////////
	// Power-on microcode

	localparam int UCODE_LEN = 14;	// Steps in the init program
	localparam int UCODE_ADDR_W = 4;

	// Spacing between steps, long enough for one full write
	localparam int STEP_CYCLES = 1024;
	localparam int STEP_CNT_W = 11;

	//////////////////////////////////////////////////
	// Register writer FSM encoding

	localparam int WR_STATE_W = 3;

	localparam logic [WR_STATE_W-1:0] WR_IDLE = 3'd0;	// Chip select high
	localparam logic [WR_STATE_W-1:0] WR_ADDR = 3'd1;	// Kick off address byte
	localparam logic [WR_STATE_W-1:0] WR_HIGH = 3'd2;	// Address out, then value MSB
	localparam logic [WR_STATE_W-1:0] WR_LOW = 3'd3;	// Value LSB
	localparam logic [WR_STATE_W-1:0] WR_CLOSE = 3'd4;	// Wait last byte, release CS

	// Five states in use, codes 5..7 fall back to idle

	// Notes on bus timing
	// SPI mode 0: clock idles low
	// Data launched on falling edge, sampled by the ADC on rising edge
	// One byte = 16 half periods = 16 * SPI_CLK_DIV ctl_clk cycles
	// Frame = address, value[15:8], value[7:0], MSB first
	// CS stays low across all three bytes

endpackage

// File: adc_ctl_tb.sv
module adc_ctl_tb;

	import adc_ctl_pkg::*;

	localparam int INIT_WRITES = 6;	// Register steps in the program
	localparam int HOST_WRITES = 4;
	localparam int DRIVE_DELAY = 5;	// After the rising edge
	localparam int DONE_LIMIT = 600;	// Cycles allowed for one frame
	localparam int TIMEOUT_CYCLES = (UCODE_LEN + 2) * STEP_CYCLES + HOST_WRITES * DONE_LIMIT;

	logic ctl_clk;
	logic arst_n;
	logic host_wr;
	logic [SPI_ADDR_W-1:0] host_addr;
	logic [SPI_VALUE_W-1:0] host_value;
	logic host_busy;
	logic host_done;
	logic init_done;
	logic spi_clk;
	logic spi_data;
	logic spi_cs_n;
	logic pd;
	logic rst_n;

	// One row per step as {rst_n, pd, write, addr, value}
	logic [SPI_FRAME_BITS+2:0] step_tab [UCODE_LEN];
	logic [SPI_ADDR_W-1:0] host_addr_tab [HOST_WRITES];
	logic [SPI_VALUE_W-1:0] host_val_tab [HOST_WRITES];

	logic [SPI_FRAME_BITS-1:0] rx_frames [$];	// Frames as seen on the bus
	int rx_bit_counts [$];
	logic [SPI_FRAME_BITS-1:0] rx_shift;
	int rx_bits;
	logic spi_clk_q;
	logic spi_cs_n_q;

	int err_cnt = 0;
	int test_cnt = 0;
	int test_fail_cnt = 0;
	int test_err_base = 0;
	string test_name;
	int rd_idx = 0;	// Next frame to check
	int cyc = 0;

	tb_clock_gen u_clk (.ctl_clk(ctl_clk), .arst_n(arst_n));

	adc_ctl_top u_dut (
		.ctl_clk(ctl_clk),
		.arst_n(arst_n),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_value(host_value),
		.host_busy(host_busy),
		.host_done(host_done),
		.init_done(init_done),
		.spi_clk(spi_clk),
		.spi_data(spi_data),
		.spi_cs_n(spi_cs_n),
		.pd(pd),
		.rst_n(rst_n)
	);

	//////////////////////////////////////////////////
	// SPI slave model sampled on ctl_clk

	always @(posedge ctl_clk or negedge arst_n) begin
		if (!arst_n) begin
			spi_clk_q <= 1'b0;
			spi_cs_n_q <= 1'b1;
			rx_bits <= 0;
		end else begin
			spi_clk_q <= spi_clk;
			spi_cs_n_q <= spi_cs_n;
			if (spi_cs_n_q && !spi_cs_n) begin	// Frame opens
				rx_bits <= 0;
			end else if (!spi_cs_n && spi_clk && !spi_clk_q) begin	// Rising spi_clk
				rx_shift <= {rx_shift[SPI_FRAME_BITS-2:0], spi_data};
				rx_bits <= rx_bits + 1;
			end else if (!spi_cs_n_q && spi_cs_n) begin	// Frame closes
				rx_frames.push_back(rx_shift);
				rx_bit_counts.push_back(rx_bits);
			end
		end
	end

	// Run limit
	always @(posedge ctl_clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cyc);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Checks and bookkeeping

	task automatic check_frame(input logic [SPI_ADDR_W-1:0] got_addr,
		input logic [SPI_ADDR_W-1:0] exp_addr, input logic [SPI_VALUE_W-1:0] got_val,
		input logic [SPI_VALUE_W-1:0] exp_val, input int got_bits);
		if (got_addr !== exp_addr) begin
			$display("FAIL t=%0t spi addr exp=%02h got=%02h", $time, exp_addr, got_addr);
			err_cnt++;
		end
		if (got_val !== exp_val) begin
			$display("FAIL t=%0t spi value exp=%04h got=%04h", $time, exp_val, got_val);
			err_cnt++;
		end
		if (got_bits != SPI_FRAME_BITS) begin
			$display("FAIL t=%0t spi bits exp=%0d got=%0d", $time, SPI_FRAME_BITS, got_bits);
			err_cnt++;
		end
	endtask

	task automatic check_pins(input logic got_rst_n, input logic got_pd,
		input logic exp_rst_n, input logic exp_pd);
		if (got_rst_n !== exp_rst_n) begin
			$display("FAIL t=%0t rst_n exp=%b got=%b", $time, exp_rst_n, got_rst_n);
			err_cnt++;
		end
		if (got_pd !== exp_pd) begin
			$display("FAIL t=%0t pd exp=%b got=%b", $time, exp_pd, got_pd);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s exp=%b got=%b", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	// Oldest unchecked frame against expected
	task automatic take_frame(input logic [SPI_ADDR_W-1:0] exp_addr,
		input logic [SPI_VALUE_W-1:0] exp_val);
		logic [SPI_FRAME_BITS-1:0] frame;
		if (rd_idx >= rx_frames.size()) begin
			$display("Error t=%0t: frame %0d never appeared on the bus", $time, rd_idx);
			err_cnt++;
		end else begin
			frame = rx_frames[rd_idx];
			check_frame(frame[SPI_FRAME_BITS-1 -: SPI_ADDR_W], exp_addr,
				frame[SPI_VALUE_W-1:0], exp_val, rx_bit_counts[rd_idx]);
			rd_idx++;
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_err_base = err_cnt;
	endtask

	task automatic close_test();
		test_cnt++;
		if (err_cnt != test_err_base) begin
			test_fail_cnt++;
			$display("test %s: failed", test_name);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	// Strobe high across one rising edge
	task automatic issue_host_write(input logic [SPI_ADDR_W-1:0] addr,
		input logic [SPI_VALUE_W-1:0] value);
		@(posedge ctl_clk);
		#DRIVE_DELAY;
		host_wr = 1'b1;
		host_addr = addr;
		host_value = value;
		@(posedge ctl_clk);
		#DRIVE_DELAY;
		host_wr = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin : main_seq
		int seed;
		int waited;
		logic [31:0] rnd;
		logic e_rst_n;
		logic e_pd;
		logic e_wr;
		logic [SPI_ADDR_W-1:0] e_addr;
		logic [SPI_VALUE_W-1:0] e_val;
		logic [SPI_ADDR_W-1:0] exp_addr_q [$];
		logic [SPI_VALUE_W-1:0] exp_val_q [$];

		host_wr = 1'b0;
		host_addr = '0;
		host_value = '0;
		seed = 32'ha99d_fd5d;

		step_tab[0] = {1'b0, 1'b0, 1'b0, 8'h00, 16'h0000};	// Reset pulse
		step_tab[1] = {1'b1, 1'b0, 1'b0, 8'h00, 16'h0000};
		step_tab[2] = {1'b1, 1'b1, 1'b0, 8'h00, 16'h0000};	// Power-down cycle
		step_tab[3] = {1'b1, 1'b0, 1'b0, 8'h00, 16'h0000};
		step_tab[4] = {1'b1, 1'b0, 1'b1, 8'h31, 16'h0001};
		step_tab[5] = {1'b1, 1'b1, 1'b0, 8'h00, 16'h0000};
		step_tab[6] = {1'b1, 1'b0, 1'b0, 8'h00, 16'h0000};
		step_tab[7] = {1'b1, 1'b0, 1'b1, 8'h3a, 16'h0202};
		step_tab[8] = {1'b1, 1'b0, 1'b1, 8'h3b, 16'h0202};
		step_tab[9] = {1'b1, 1'b0, 1'b1, 8'h53, 16'h0000};
		step_tab[10] = {1'b1, 1'b1, 1'b0, 8'h00, 16'h0000};
		step_tab[11] = {1'b1, 1'b0, 1'b0, 8'h00, 16'h0000};
		step_tab[12] = {1'b1, 1'b0, 1'b1, 8'h56, 16'h0008};
		step_tab[13] = {1'b1, 1'b0, 1'b1, 8'h30, 16'h00ff};
		for (int h = 0; h < HOST_WRITES; h++) begin
			rnd = $random(seed);
			host_addr_tab[h] = rnd[SPI_ADDR_W-1:0];
			rnd = $random(seed);
			host_val_tab[h] = rnd[SPI_VALUE_W-1:0];
		end

		@(posedge arst_n);
		open_test("reset values");
		repeat (STEP_CYCLES - 1) begin	// Up to the edge before step 0
			@(negedge ctl_clk);
			check_flag("spi_cs_n", spi_cs_n, 1'b1);
			check_flag("spi_clk", spi_clk, 1'b0);
			check_flag("init_done", init_done, 1'b0);
			check_flag("host_busy", host_busy, 1'b0);
			check_flag("host_done", host_done, 1'b0);
			check_pins(rst_n, pd, 1'b1, 1'b0);
		end
		close_test();

		for (int s = 0; s < UCODE_LEN; s++) begin
			{e_rst_n, e_pd, e_wr, e_addr, e_val} = step_tab[s];
			open_test($sformatf("step %0d pins", s));
			@(negedge ctl_clk);	// Step edge just passed
			check_pins(rst_n, pd, e_rst_n, e_pd);
			check_flag("init_done", init_done, s == UCODE_LEN - 1);
			if (e_wr) begin
				exp_addr_q.push_back(e_addr);
				exp_val_q.push_back(e_val);
			end
			if (s < UCODE_LEN - 1) begin
				repeat (STEP_CYCLES - 1) @(negedge ctl_clk);
				check_pins(rst_n, pd, e_rst_n, e_pd);	// Held until the next step
			end
			close_test();
		end

		// Last init frame still on the wire
		waited = 0;
		while (rx_frames.size() < INIT_WRITES && waited < DONE_LIMIT) begin
			@(negedge ctl_clk);
			waited++;
		end
		for (int i = 0; i < INIT_WRITES; i++) begin
			open_test($sformatf("init frame %0d", i));
			take_frame(exp_addr_q[i], exp_val_q[i]);
			close_test();
		end

		for (int h = 0; h < HOST_WRITES; h++) begin
			open_test($sformatf("host write %0d", h));
			issue_host_write(host_addr_tab[h], host_val_tab[h]);
			repeat (2) @(negedge ctl_clk);	// Sequencer register, then writer accept
			check_flag("host_busy", host_busy, 1'b1);
			check_flag("spi_cs_n", spi_cs_n, 1'b0);
			issue_host_write(~host_addr_tab[h], ~host_val_tab[h]);	// Lands while busy
			waited = 0;
			while (!host_done && waited < DONE_LIMIT) begin
				check_flag("host_busy", host_busy, 1'b1);
				@(negedge ctl_clk);
				waited++;
			end
			if (!host_done) begin
				$display("Error t=%0t: no host_done within %0d cycles", $time, DONE_LIMIT);
				err_cnt++;
			end
			@(negedge ctl_clk);	// Slave model has the frame now
			check_flag("host_done", host_done, 1'b0);
			take_frame(host_addr_tab[h], host_val_tab[h]);
			close_test();
		end

		open_test("busy rule");
		repeat (DONE_LIMIT) @(negedge ctl_clk);
		if (rx_frames.size() != INIT_WRITES + HOST_WRITES) begin
			$display("Error t=%0t: %0d frames on the bus but %0d writes accepted", $time,
				rx_frames.size(), INIT_WRITES + HOST_WRITES);
			err_cnt++;
		end
		check_flag("spi_cs_n", spi_cs_n, 1'b1);
		close_test();

		$display("tests %0d, failed %0d, check errors %0d", test_cnt, test_fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: adc_ctl_top.sv
module adc_ctl_top (
	input  logic ctl_clk,
	input  logic arst_n,

	// Host register port
	input  logic host_wr,
	input  logic [adc_ctl_pkg::SPI_ADDR_W-1:0] host_addr,
	input  logic [adc_ctl_pkg::SPI_VALUE_W-1:0] host_value,
	output logic host_busy,
	output logic host_done,
	output logic init_done,

	// ADC pins
	output logic spi_clk,
	output logic spi_data,
	output logic spi_cs_n,
	output logic pd,
	output logic rst_n
);

	import adc_ctl_pkg::*;

	//////////////////////////////////////////////////
	// Internal links

	logic reg_wr;
	logic [SPI_ADDR_W-1:0] reg_addr;
	logic [SPI_VALUE_W-1:0] reg_value;

	logic shift_en;
	logic shift_done;
	logic [SPI_ADDR_W-1:0] tx_data;	// One byte per shift

	adc_init_sequencer u_seq (
		.ctl_clk(ctl_clk),
		.arst_n(arst_n),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_value(host_value),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_value(reg_value),
		.rst_n(rst_n),
		.pd(pd),
		.init_done(init_done)
	);

	adc_reg_writer u_writer (
		.ctl_clk(ctl_clk),
		.arst_n(arst_n),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_value(reg_value),
		.reg_busy(host_busy),	// Busy and done go straight to the host
		.reg_done(host_done),
		.spi_cs_n(spi_cs_n),
		.shift_en(shift_en),
		.tx_data(tx_data),
		.shift_done(shift_done)
	);

	spi_transceiver u_spi (
		.ctl_clk(ctl_clk),
		.arst_n(arst_n),
		.shift_en(shift_en),
		.tx_data(tx_data),
		.shift_done(shift_done),
		.spi_clk(spi_clk),
		.spi_data(spi_data)
	);

endmodule

// File: adc_init_sequencer.sv
module adc_init_sequencer (
	input  logic ctl_clk,
	input  logic arst_n,

	// Host register writes, honoured after init
	input  logic host_wr,
	input  logic [adc_ctl_pkg::SPI_ADDR_W-1:0] host_addr,
	input  logic [adc_ctl_pkg::SPI_VALUE_W-1:0] host_value,

	// To the register writer
	output logic reg_wr,
	output logic [adc_ctl_pkg::SPI_ADDR_W-1:0] reg_addr,
	output logic [adc_ctl_pkg::SPI_VALUE_W-1:0] reg_value,

	// ADC control pins and status
	output logic rst_n,
	output logic pd,
	output logic init_done
);

	import adc_ctl_pkg::*;

	logic [UCODE_ADDR_W-1:0] step_idx;	// Current microcode line
	logic [STEP_CNT_W-1:0] step_cnt;
	logic step_fire;

	// Decoded microcode line
	logic uc_wr;
	logic [SPI_ADDR_W-1:0] uc_reg;
	logic [SPI_VALUE_W-1:0] uc_val;
	logic uc_rst_n;
	logic uc_pd;

	assign step_fire = !init_done && (step_cnt == STEP_CNT_W'(STEP_CYCLES - 1));

	//////////////////////////////////////////////////
	// Power-on microcode ROM

	always_comb begin
		uc_wr = 1'b0;
		uc_reg = '0;
		uc_val = '0;
		uc_rst_n = 1'b1;	// Pins idle: out of reset, powered up
		uc_pd = 1'b0;
		case (step_idx)
			4'd0: uc_rst_n = 1'b0;	// Reset pulse
			4'd1: uc_rst_n = 1'b1;
			4'd2: uc_pd = 1'b1;	// Power-down cycle
			4'd3: uc_pd = 1'b0;
			4'd4: begin	// Single channel mode, no clock divide
				uc_wr = 1'b1;
				uc_reg = 8'h31;
				uc_val = 16'h0001;
			end
			4'd5: uc_pd = 1'b1;	// Power-down cycle
			4'd6: uc_pd = 1'b0;
			4'd7: begin	// Input select, ADC 1 and 2
				uc_wr = 1'b1;
				uc_reg = 8'h3a;
				uc_val = 16'h0202;
			end
			4'd8: begin	// Input select, ADC 3 and 4
				uc_wr = 1'b1;
				uc_reg = 8'h3b;
				uc_val = 16'h0202;
			end
			4'd9: begin
				uc_wr = 1'b1;
				uc_reg = 8'h53;
				uc_val = 16'h0000;
			end
			4'd10: uc_pd = 1'b1;	// Power-down cycle
			4'd11: uc_pd = 1'b0;
			4'd12: begin
				uc_wr = 1'b1;
				uc_reg = 8'h56;
				uc_val = 16'h0008;
			end
			4'd13: begin
				uc_wr = 1'b1;
				uc_reg = 8'h30;
				uc_val = 16'h00ff;
			end
			default: ;	// Past the end, defaults hold
		endcase
	end

	//////////////////////////////////////////////////
	// Step timer and pin drivers

	always_ff @(posedge ctl_clk or negedge arst_n) begin
		if (!arst_n) begin
			step_cnt <= '0;
			step_idx <= '0;
			reg_wr <= 1'b0;
			rst_n <= 1'b1;
			pd <= 1'b0;
			init_done <= 1'b0;
		end else begin
			reg_wr <= 1'b0;
			if (init_done) begin
				reg_wr <= host_wr;	// Host path, one cycle late
			end else if (step_fire) begin
				step_cnt <= '0;
				step_idx <= step_idx + UCODE_ADDR_W'(1);
				reg_wr <= uc_wr;
				rst_n <= uc_rst_n;
				pd <= uc_pd;
				if (step_idx == UCODE_ADDR_W'(UCODE_LEN - 1))
					init_done <= 1'b1;	// Timer stops here
			end else begin
				step_cnt <= step_cnt + STEP_CNT_W'(1);
			end
		end
	end

	// Write payload follows the strobe source
	always_ff @(posedge ctl_clk) begin
		if (init_done) begin
			reg_addr <= host_addr;
			reg_value <= host_value;
		end else if (step_fire) begin
			reg_addr <= uc_reg;
			reg_value <= uc_val;
		end
	end

endmodule

// File: adc_reg_writer.sv
module adc_reg_writer (
	input  logic ctl_clk,
	input  logic arst_n,

	// Register write request
	input  logic reg_wr,
	input  logic [adc_ctl_pkg::SPI_ADDR_W-1:0] reg_addr,
	input  logic [adc_ctl_pkg::SPI_VALUE_W-1:0] reg_value,
	output logic reg_busy,
	output logic reg_done,

	// Toward the ADC and the byte shifter
	output logic spi_cs_n,
	output logic shift_en,
	output logic [adc_ctl_pkg::SPI_ADDR_W-1:0] tx_data,
	input  logic shift_done
);

	import adc_ctl_pkg::*;

	logic [WR_STATE_W-1:0] state;
	logic [SPI_FRAME_BITS-1:0] frame_q;	// Address and value, latched at accept

	assign reg_busy = (state != WR_IDLE);

	//////////////////////////////////////////////////
	// Frame sequencing

	always_ff @(posedge ctl_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= WR_IDLE;
			spi_cs_n <= 1'b1;
			shift_en <= 1'b0;
			reg_done <= 1'b0;
		end else begin
			shift_en <= 1'b0;
			reg_done <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (reg_wr) begin	// Requests while busy never get here
						spi_cs_n <= 1'b0;
						state <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					shift_en <= 1'b1;
					state <= WR_HIGH;
				end
				WR_HIGH: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						state <= WR_LOW;
					end
				end
				WR_LOW: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						state <= WR_CLOSE;
					end
				end
				WR_CLOSE: begin
					if (shift_done) begin
						reg_done <= 1'b1;	// Same cycle as CS rising
						spi_cs_n <= 1'b1;
						state <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Frame data and byte select

	always_ff @(posedge ctl_clk) begin
		if (state == WR_IDLE && reg_wr)
			frame_q <= {reg_addr, reg_value};
		if (state == WR_ADDR)
			tx_data <= frame_q[SPI_FRAME_BITS-1 -: SPI_ADDR_W];
		else if (state == WR_HIGH && shift_done)
			tx_data <= frame_q[SPI_VALUE_W-1 -: SPI_ADDR_W];	// Value MSB
		else if (state == WR_LOW && shift_done)
			tx_data <= frame_q[SPI_ADDR_W-1:0];
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module adc_ctl_tb -f verilog.f -o adc_ctl_sim \
	&& ./obj_dir/adc_ctl_sim > sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: spi_transceiver.sv
module spi_transceiver (
	input  logic ctl_clk,
	input  logic arst_n,

	// Byte request from the register writer
	input  logic shift_en,
	input  logic [adc_ctl_pkg::SPI_ADDR_W-1:0] tx_data,
	output logic shift_done,

	// Serial side
	output logic spi_clk,
	output logic spi_data
);

	import adc_ctl_pkg::*;

	logic busy;	// Byte in flight
	logic [SPI_DIV_W-1:0] div_cnt;	// Half period divider
	logic [3:0] half_cnt;	// 16 half periods per byte
	logic [SPI_ADDR_W-1:0] sreg;	// Remaining bits, MSB next

	logic load;
	logic tick;
	logic fall;
	logic last;

	assign load = shift_en && !busy;
	assign tick = busy && (div_cnt == SPI_DIV_W'(SPI_CLK_DIV - 1));	// End of a half period
	assign fall = tick && spi_clk;	// Clock about to drop
	assign last = (half_cnt == 4'(2 * SPI_ADDR_W - 1));

	//////////////////////////////////////////////////
	// Clock generation and bit timing

	always_ff @(posedge ctl_clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			div_cnt <= '0;
			half_cnt <= '0;
			spi_clk <= 1'b0;	// Mode 0 idle level
			spi_data <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				div_cnt <= '0;
				half_cnt <= '0;
				spi_data <= tx_data[SPI_ADDR_W-1];	// MSB valid before first rise
			end else if (tick) begin
				div_cnt <= '0;
				spi_clk <= ~spi_clk;
				half_cnt <= half_cnt + 4'd1;
				if (fall) begin
					if (last) begin
						busy <= 1'b0;	// Eighth rise done, clock back low
						shift_done <= 1'b1;
					end else begin
						spi_data <= sreg[SPI_ADDR_W-1];	// Next bit on falling edge
					end
				end
			end else if (busy) begin
				div_cnt <= div_cnt + SPI_DIV_W'(1);
			end
		end
	end

	//////////////////////////////////////////////////
	// Shift register

	always_ff @(posedge ctl_clk) begin
		if (load)
			sreg <= {tx_data[SPI_ADDR_W-2:0], 1'b0};	// MSB already on the pin
		else if (fall && !last)
			sreg <= {sreg[SPI_ADDR_W-2:0], 1'b0};
	end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
	output logic ctl_clk,
	output logic arst_n
);

	localparam int HALF_PERIOD = 20;	// 40 per cycle
	localparam int RESET_CYCLES = 8;

	initial begin
		ctl_clk = 1'b0;
		forever #HALF_PERIOD ctl_clk = ~ctl_clk;
	end

	// Release on a falling edge, away from the DUT's active edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge ctl_clk);
		@(negedge ctl_clk);
		arst_n = 1'b1;
	end

endmodule

// File: verilog.f
adc_ctl_pkg.sv
spi_transceiver.sv
adc_reg_writer.sv
adc_init_sequencer.sv
adc_ctl_top.sv
tb_clock_gen.sv
adc_ctl_assertions.sv
adc_ctl_tb.sv
